/* include/cache_macros.svh */
/*
  Geometry of the two-way write-back cache.
  The tag width is derived from the other sizes.
*/
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

`define CACHE_ADDR_WIDTH 16
`define CACHE_DATA_WIDTH 32
`define CACHE_BLOCK_WORDS 4
`define CACHE_SETS 8
`define CACHE_TAG_WIDTH (`CACHE_ADDR_WIDTH - $clog2(`CACHE_DATA_WIDTH / 8) \
  - $clog2(`CACHE_BLOCK_WORDS) - $clog2(`CACHE_SETS))

`endif

/* logic/cache_pkg.sv */
/*
  Cache-side types: request opcodes and the miss controller states.
*/
package cache_pkg;

  typedef enum logic [2:0] {
    OP_LD,
    OP_ST,
    OP_TAGFL,  // Way is named by address bit 7.
    OP_AFL,
    OP_AFLINV,
    OP_AINV
  } cache_op_e;

  typedef enum logic [2:0] {
    START,
    FLUSH_OP,
    SEND_EVICT_ADDR,
    SEND_FILL_ADDR,
    SEND_EVICT_DATA,
    GET_FILL_DATA,
    RECOVER,
    DONE
  } miss_state_e;

endpackage

/* logic/dma_pkg.sv */
/*
  Memory-side types: states of the block mover.
*/
package dma_pkg;

  typedef enum logic [1:0] {
    DMA_IDLE,
    DMA_EVICT,
    DMA_FILL,
    DMA_DONE  // One-cycle completion pulse.
  } dma_state_e;

endpackage

/* logic/cache_miss.sv */
/*
  Miss and flush controller.
  Picks the victim way, writes tag and status, and orders DMA evictions and fills.
*/
`include "cache_macros.svh"

module cache_miss #(
  localparam int ADDR_W = `CACHE_ADDR_WIDTH,
  localparam int TAG_W = `CACHE_TAG_WIDTH,
  localparam int BYTE_W = $clog2(`CACHE_DATA_WIDTH / 8),
  localparam int OFF_W = $clog2(`CACHE_BLOCK_WORDS),
  localparam int IDX_W = $clog2(`CACHE_SETS)
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic miss_v_i,
  input  logic st_op_v_i,
  input  logic tagfl_op_v_i,
  input  logic afl_op_v_i,
  input  logic aflinv_op_v_i,
  input  logic ainv_op_v_i,
  input  logic [ADDR_W-1:0] addr_v_i,
  input  logic [1:0][TAG_W-1:0] tag_v_i,
  input  logic [1:0] valid_v_i,
  input  logic [1:0] tag_hit_v_i,
  input  logic [1:0] dirty_i,
  input  logic mru_i,
  input  logic dma_done_i,
  input  logic ack_i,
  output logic dma_send_fill_addr_o,
  output logic dma_send_evict_addr_o,
  output logic dma_get_fill_data_o,
  output logic dma_send_evict_data_o,
  output logic dma_set_o,
  output logic [ADDR_W-1:0] dma_addr_o,
  output logic stat_mem_v_o,
  output logic stat_mem_w_o,
  output logic [IDX_W-1:0] stat_mem_addr_o,
  output logic [2:0] stat_mem_data_o,
  output logic [2:0] stat_mem_w_mask_o,
  output logic tag_mem_v_o,
  output logic tag_mem_w_o,
  output logic [IDX_W-1:0] tag_mem_addr_o,
  output logic [1:0][TAG_W:0] tag_mem_data_o,
  output logic [1:0][TAG_W:0] tag_mem_w_mask_o,
  output logic recover_o,
  output logic done_o,
  output logic chosen_set_o
);

  cache_pkg::miss_state_e state_r;
  cache_pkg::miss_state_e state_n;
  logic chosen_set_r, chosen_set_n;
  logic stat_flopped_r, stat_flopped_n;
  logic [1:0] dirty_r, dirty_n;
  logic mru_r, mru_n;
  logic flush_op, flush_hit;
  logic [TAG_W-1:0] addr_tag;
  logic [IDX_W-1:0] addr_index;
  logic [ADDR_W-1:0] fill_addr, evict_addr;

  assign flush_op = tagfl_op_v_i | afl_op_v_i | aflinv_op_v_i | ainv_op_v_i;
  assign flush_hit = tagfl_op_v_i | (|tag_hit_v_i); // Address flushes act on a hit way only.
  assign addr_index = addr_v_i[BYTE_W+OFF_W +: IDX_W];
  assign addr_tag = addr_v_i[BYTE_W+OFF_W+IDX_W +: TAG_W];
  assign fill_addr = {addr_tag, addr_index, {(OFF_W + BYTE_W){1'b0}}};
  assign evict_addr = {tag_v_i[chosen_set_r], addr_index, {(OFF_W + BYTE_W){1'b0}}};
  assign chosen_set_o = chosen_set_r;

  always_comb begin
    state_n = state_r;
    chosen_set_n = chosen_set_r;
    stat_flopped_n = stat_flopped_r;
    dirty_n = dirty_r;
    mru_n = mru_r;
    dma_send_fill_addr_o = 1'b0;
    dma_send_evict_addr_o = 1'b0;
    dma_get_fill_data_o = 1'b0;
    dma_send_evict_data_o = 1'b0;
    dma_set_o = 1'b0;
    dma_addr_o = '0;
    stat_mem_v_o = 1'b0;
    stat_mem_w_o = 1'b0;
    stat_mem_addr_o = addr_index;
    stat_mem_data_o = '0;
    stat_mem_w_mask_o = '0;
    tag_mem_v_o = 1'b0;
    tag_mem_w_o = 1'b0;
    tag_mem_addr_o = addr_index;
    tag_mem_data_o = '0;
    tag_mem_w_mask_o = '0;
    recover_o = 1'b0;
    done_o = 1'b0;
    case (state_r)
      cache_pkg::START: begin
        stat_flopped_n = 1'b0;
        if (miss_v_i) begin
          state_n = flush_op ? cache_pkg::FLUSH_OP : cache_pkg::SEND_FILL_ADDR;
        end
      end
      cache_pkg::SEND_FILL_ADDR: begin
        stat_flopped_n = 1'b1;
        mru_n = stat_flopped_r ? mru_r : mru_i;
        dirty_n = stat_flopped_r ? dirty_r : dirty_i;
        // An invalid way goes first, then the least recently used one.
        chosen_set_n = ~valid_v_i[0] ? 1'b0 : (~valid_v_i[1] ? 1'b1 : ~mru_n);
        dma_send_fill_addr_o = 1'b1;
        dma_addr_o = fill_addr;
        stat_mem_v_o = dma_done_i;
        stat_mem_w_o = dma_done_i;
        stat_mem_data_o = {{2{st_op_v_i}}, chosen_set_n};
        stat_mem_w_mask_o = {chosen_set_n, ~chosen_set_n, 1'b1};
        tag_mem_v_o = dma_done_i;
        tag_mem_w_o = dma_done_i;
        tag_mem_data_o = {2{1'b1, addr_tag}};
        tag_mem_w_mask_o = {{(TAG_W + 1){chosen_set_n}}, {(TAG_W + 1){~chosen_set_n}}};
        if (dma_done_i) begin
          state_n = (dirty_n[chosen_set_n] & valid_v_i[chosen_set_n])
            ? cache_pkg::SEND_EVICT_ADDR : cache_pkg::GET_FILL_DATA;
        end
      end
      cache_pkg::FLUSH_OP: begin
        stat_flopped_n = 1'b1;
        dirty_n = stat_flopped_r ? dirty_r : dirty_i;
        chosen_set_n = tagfl_op_v_i ? addr_v_i[BYTE_W+OFF_W+IDX_W] : tag_hit_v_i[1];
        stat_mem_v_o = flush_hit;
        stat_mem_w_o = flush_hit;
        stat_mem_data_o = {2'b00, ~chosen_set_n};
        stat_mem_w_mask_o = {chosen_set_n, ~chosen_set_n, 1'b1};
        tag_mem_v_o = flush_hit;
        tag_mem_w_o = flush_hit;
        tag_mem_data_o = {2{valid_v_i[chosen_set_n] & ~(ainv_op_v_i | aflinv_op_v_i),
          {TAG_W{1'b0}}}};
        tag_mem_w_mask_o = {chosen_set_n, {TAG_W{1'b0}}, ~chosen_set_n, {TAG_W{1'b0}}};
        state_n = (flush_hit & ~ainv_op_v_i & dirty_n[chosen_set_n] & valid_v_i[chosen_set_n])
          ? cache_pkg::SEND_EVICT_ADDR : cache_pkg::RECOVER;
      end
      cache_pkg::SEND_EVICT_ADDR: begin
        dma_send_evict_addr_o = 1'b1;
        dma_addr_o = evict_addr; // Old tag, still held by the core.
        if (dma_done_i) begin
          state_n = cache_pkg::SEND_EVICT_DATA;
        end
      end
      cache_pkg::SEND_EVICT_DATA: begin
        dma_send_evict_data_o = 1'b1;
        dma_set_o = chosen_set_r;
        dma_addr_o = evict_addr;
        if (dma_done_i) begin
          state_n = flush_op ? cache_pkg::RECOVER : cache_pkg::GET_FILL_DATA;
        end
      end
      cache_pkg::GET_FILL_DATA: begin
        dma_get_fill_data_o = 1'b1;
        dma_set_o = chosen_set_r;
        dma_addr_o = fill_addr;
        if (dma_done_i) begin
          state_n = cache_pkg::RECOVER;
        end
      end
      cache_pkg::RECOVER: begin
        recover_o = 1'b1;
        state_n = cache_pkg::DONE;
      end
      default: begin
        done_o = 1'b1;
        if (ack_i) begin
          state_n = cache_pkg::START;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= cache_pkg::START;
      chosen_set_r <= 1'b0;
      stat_flopped_r <= 1'b0;
    end else begin
      state_r <= state_n;
      chosen_set_r <= chosen_set_n;
      stat_flopped_r <= stat_flopped_n;
    end
  end

  always_ff @(posedge clk_i) begin
    dirty_r <= dirty_n;
    mru_r <= mru_n;
  end

endmodule

/* logic/cache_dma.sv */
/*
  Block mover between the data array and backing memory.
  Latches block addresses, then moves four words per eviction or fill.
*/
`include "cache_macros.svh"

module cache_dma #(
  localparam int ADDR_W = `CACHE_ADDR_WIDTH,
  localparam int DATA_W = `CACHE_DATA_WIDTH,
  localparam int BYTE_W = $clog2(`CACHE_DATA_WIDTH / 8),
  localparam int OFF_W = $clog2(`CACHE_BLOCK_WORDS),
  localparam int IDX_W = $clog2(`CACHE_SETS),
  localparam int DADDR_W = 1 + IDX_W + OFF_W
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic send_fill_addr_i,
  input  logic send_evict_addr_i,
  input  logic get_fill_data_i,
  input  logic send_evict_data_i,
  input  logic set_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] data_rdata_i,
  input  logic [DATA_W-1:0] mem_rdata_i,
  input  logic mem_ack_i,
  output logic done_o,
  output logic data_v_o,
  output logic data_w_o,
  output logic [DADDR_W-1:0] data_addr_o,
  output logic [DATA_W-1:0] data_wdata_o,
  output logic mem_req_o,
  output logic mem_we_o,
  output logic [ADDR_W-1:0] mem_addr_o,
  output logic [DATA_W-1:0] mem_wdata_o
);

  dma_pkg::dma_state_e state_r;
  dma_pkg::dma_state_e state_n;
  logic [OFF_W-1:0] cnt_r, cnt_n;
  logic rd_done_r, rd_done_n; // Word read from the array, now going to memory.
  logic [ADDR_W-1:0] fill_addr_r, evict_addr_r;
  logic [ADDR_W-1:0] blk_addr;

  assign blk_addr = (state_r == dma_pkg::DMA_FILL) ? fill_addr_r : evict_addr_r;
  assign mem_addr_o = {blk_addr[ADDR_W-1:OFF_W+BYTE_W], cnt_r, {BYTE_W{1'b0}}};
  assign data_addr_o = {set_i, blk_addr[BYTE_W+OFF_W +: IDX_W], cnt_r};
  assign data_wdata_o = mem_rdata_i;
  assign mem_wdata_o = data_rdata_i; // The array read register holds until the ack.

  always_comb begin
    state_n = state_r;
    cnt_n = cnt_r;
    rd_done_n = rd_done_r;
    done_o = 1'b0;
    data_v_o = 1'b0;
    data_w_o = 1'b0;
    mem_req_o = 1'b0;
    mem_we_o = 1'b0;
    case (state_r)
      dma_pkg::DMA_IDLE: begin
        cnt_n = '0;
        rd_done_n = 1'b0;
        if (send_fill_addr_i | send_evict_addr_i) begin
          state_n = dma_pkg::DMA_DONE;
        end else if (send_evict_data_i) begin
          state_n = dma_pkg::DMA_EVICT;
        end else if (get_fill_data_i) begin
          state_n = dma_pkg::DMA_FILL;
        end
      end
      dma_pkg::DMA_EVICT: begin
        if (!rd_done_r) begin
          data_v_o = 1'b1;
          rd_done_n = 1'b1;
        end else begin
          mem_req_o = 1'b1;
          mem_we_o = 1'b1;
          if (mem_ack_i) begin
            rd_done_n = 1'b0;
            cnt_n = cnt_r + 1'b1;
            if (&cnt_r) begin
              state_n = dma_pkg::DMA_DONE;
            end
          end
        end
      end
      dma_pkg::DMA_FILL: begin
        mem_req_o = 1'b1;
        if (mem_ack_i) begin
          data_v_o = 1'b1;
          data_w_o = 1'b1;
          cnt_n = cnt_r + 1'b1;
          if (&cnt_r) begin
            state_n = dma_pkg::DMA_DONE;
          end
        end
      end
      default: begin
        done_o = 1'b1;
        state_n = dma_pkg::DMA_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= dma_pkg::DMA_IDLE;
      cnt_r <= '0;
      rd_done_r <= 1'b0;
    end else begin
      state_r <= state_n;
      cnt_r <= cnt_n;
      rd_done_r <= rd_done_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_r == dma_pkg::DMA_IDLE && send_fill_addr_i) fill_addr_r <= addr_i;
    if (state_r == dma_pkg::DMA_IDLE && send_evict_addr_i) evict_addr_r <= addr_i;
  end

endmodule

/* logic/cache_core.sv */
/*
  Cache pipeline: request stage, tag, status and data arrays, and hit logic.
  Also replays a held request after recovery and shares the data array with DMA.
*/
`include "cache_macros.svh"

module cache_core #(
  localparam int ADDR_W = `CACHE_ADDR_WIDTH,
  localparam int DATA_W = `CACHE_DATA_WIDTH,
  localparam int TAG_W = `CACHE_TAG_WIDTH,
  localparam int BYTE_W = $clog2(`CACHE_DATA_WIDTH / 8),
  localparam int OFF_W = $clog2(`CACHE_BLOCK_WORDS),
  localparam int IDX_W = $clog2(`CACHE_SETS),
  localparam int DADDR_W = 1 + IDX_W + OFF_W
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic req_v_i,
  input  cache_pkg::cache_op_e req_op_i,
  input  logic [ADDR_W-1:0] req_addr_i,
  input  logic [DATA_W-1:0] req_data_i,
  output logic ready_o,
  output logic resp_v_o,
  output logic [DATA_W-1:0] resp_data_o,
  output logic miss_v_o,
  output logic st_op_v_o,
  output logic tagfl_op_v_o,
  output logic afl_op_v_o,
  output logic aflinv_op_v_o,
  output logic ainv_op_v_o,
  output logic [ADDR_W-1:0] addr_v_o,
  output logic [1:0][TAG_W-1:0] tag_v_o,
  output logic [1:0] valid_v_o,
  output logic [1:0] tag_hit_v_o,
  output logic [1:0] dirty_o,
  output logic mru_o,
  output logic ack_o,
  input  logic stat_mem_v_i,
  input  logic stat_mem_w_i,
  input  logic [IDX_W-1:0] stat_mem_addr_i,
  input  logic [2:0] stat_mem_data_i,
  input  logic [2:0] stat_mem_w_mask_i,
  input  logic tag_mem_v_i,
  input  logic tag_mem_w_i,
  input  logic [IDX_W-1:0] tag_mem_addr_i,
  input  logic [1:0][TAG_W:0] tag_mem_data_i,
  input  logic [1:0][TAG_W:0] tag_mem_w_mask_i,
  input  logic recover_i,
  input  logic done_i,
  input  logic chosen_set_i,
  input  logic dma_data_v_i,
  input  logic dma_data_w_i,
  input  logic [DADDR_W-1:0] dma_data_addr_i,
  input  logic [DATA_W-1:0] dma_data_wdata_i,
  output logic [DATA_W-1:0] data_rdata_o
);

  logic [1:0][TAG_W:0] tag_mem [`CACHE_SETS]; // {valid, tag} per way.
  logic [2:0] stat_mem [`CACHE_SETS];         // {dirty1, dirty0, mru}.
  logic [DATA_W-1:0] data_mem [2 * `CACHE_SETS * `CACHE_BLOCK_WORDS];

  cache_pkg::cache_op_e op_r;
  logic v_r, busy_r, replay_r;
  logic [DATA_W-1:0] data_r;
  logic [1:0][TAG_W:0] tag_rd_r;
  logic [2:0] stat_rd_r;
  logic [1:0][DATA_W-1:0] data_rd_r;
  logic accept, rd_en, stall, is_ld, is_st, miss, way;
  logic [ADDR_W-1:0] rd_addr;
  logic [IDX_W-1:0] rd_idx, idx_r;
  logic [OFF_W-1:0] rd_off, off_r;
  logic tag_we, stat_we, data_we;
  logic [1:0][TAG_W:0] tag_wval;
  logic [IDX_W-1:0] stat_waddr;
  logic [2:0] stat_wdata, stat_wmask, stat_wval;
  logic [DADDR_W-1:0] data_waddr;
  logic [DATA_W-1:0] data_wdata;

  assign accept = req_v_i & ready_o;
  assign rd_en = accept | recover_i; // Recovery re-reads the arrays for the held request.
  assign rd_addr = accept ? req_addr_i : addr_v_o;
  assign rd_idx = rd_addr[BYTE_W+OFF_W +: IDX_W];
  assign rd_off = rd_addr[BYTE_W +: OFF_W];
  assign idx_r = addr_v_o[BYTE_W+OFF_W +: IDX_W];
  assign off_r = addr_v_o[BYTE_W +: OFF_W];

  assign is_ld = (op_r == cache_pkg::OP_LD);
  assign is_st = (op_r == cache_pkg::OP_ST);
  assign st_op_v_o = is_st;
  assign tagfl_op_v_o = (op_r == cache_pkg::OP_TAGFL);
  assign afl_op_v_o = (op_r == cache_pkg::OP_AFL);
  assign aflinv_op_v_o = (op_r == cache_pkg::OP_AFLINV);
  assign ainv_op_v_o = (op_r == cache_pkg::OP_AINV);

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      valid_v_o[w] = tag_rd_r[w][TAG_W];
      tag_v_o[w] = tag_rd_r[w][TAG_W-1:0];
      tag_hit_v_o[w] = valid_v_o[w] & (tag_v_o[w] == addr_v_o[ADDR_W-1 -: TAG_W]);
    end
  end

  assign miss = tagfl_op_v_o | afl_op_v_o | aflinv_op_v_o | ainv_op_v_o | ~(|tag_hit_v_o);
  assign miss_v_o = v_r & ~busy_r & ~replay_r & miss;
  assign resp_v_o = v_r & ~busy_r & (replay_r | ~miss);
  assign ready_o = ~v_r | resp_v_o;
  assign stall = v_r & ~resp_v_o;
  assign ack_o = done_i;
  assign way = replay_r ? chosen_set_i : tag_hit_v_o[1];
  assign resp_data_o = is_ld ? data_rd_r[way] : '0;
  assign dirty_o = stat_rd_r[2:1];
  assign mru_o = stat_rd_r[0];

  // Write ports belong to the miss controller and DMA while stalled.
  always_comb begin
    tag_we = tag_mem_v_i & tag_mem_w_i;
    tag_wval = (tag_mem[tag_mem_addr_i] & ~tag_mem_w_mask_i) | (tag_mem_data_i & tag_mem_w_mask_i);
    stat_we = stall ? (stat_mem_v_i & stat_mem_w_i) : (resp_v_o & (is_ld | is_st));
    stat_waddr = stall ? stat_mem_addr_i : idx_r;
    stat_wdata = stall ? stat_mem_data_i : {2'b11, way};
    stat_wmask = stall ? stat_mem_w_mask_i : {way & is_st, ~way & is_st, 1'b1};
    stat_wval = (stat_mem[stat_waddr] & ~stat_wmask) | (stat_wdata & stat_wmask);
    data_we = stall ? (dma_data_v_i & dma_data_w_i) : (resp_v_o & is_st);
    data_waddr = stall ? dma_data_addr_i : {way, idx_r, off_r};
    data_wdata = stall ? dma_data_wdata_i : data_r;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        tag_mem[s] <= '0;
        stat_mem[s] <= '0;
      end
    end else begin
      if (tag_we) tag_mem[tag_mem_addr_i] <= tag_wval;
      if (stat_we) stat_mem[stat_waddr] <= stat_wval;
    end
  end

  // Reads see a write to the same entry in the same cycle.
  always_ff @(posedge clk_i) begin
    if (data_we) data_mem[data_waddr] <= data_wdata;
    if (dma_data_v_i && !dma_data_w_i) data_rdata_o <= data_mem[dma_data_addr_i];
    if (rd_en) begin
      tag_rd_r <= (tag_we && tag_mem_addr_i == rd_idx) ? tag_wval : tag_mem[rd_idx];
      stat_rd_r <= (stat_we && stat_waddr == rd_idx) ? stat_wval : stat_mem[rd_idx];
      for (int w = 0; w < 2; w++) begin
        data_rd_r[w] <= (data_we && data_waddr == {1'(w), rd_idx, rd_off})
          ? data_wdata : data_mem[{1'(w), rd_idx, rd_off}];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_r <= 1'b0;
      busy_r <= 1'b0;
      replay_r <= 1'b0;
    end else begin
      v_r <= accept | (v_r & ~resp_v_o);
      busy_r <= miss_v_o | (busy_r & ~ack_o);
      replay_r <= ack_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_r <= req_op_i;
      addr_v_o <= req_addr_i;
      data_r <= req_data_i;
    end
  end

endmodule

/* logic/cache_top.sv */
/*
  Top level of the two-way cache: core, miss controller and DMA engine.
*/
`include "cache_macros.svh"

module cache_top #(
  localparam int ADDR_W = `CACHE_ADDR_WIDTH,
  localparam int DATA_W = `CACHE_DATA_WIDTH,
  localparam int TAG_W = `CACHE_TAG_WIDTH,
  localparam int IDX_W = $clog2(`CACHE_SETS),
  localparam int DADDR_W = 1 + IDX_W + $clog2(`CACHE_BLOCK_WORDS)
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic req_v_i,
  input  cache_pkg::cache_op_e req_op_i,
  input  logic [ADDR_W-1:0] req_addr_i,
  input  logic [DATA_W-1:0] req_data_i,
  output logic ready_o,
  output logic resp_v_o,
  output logic [DATA_W-1:0] resp_data_o,
  output logic mem_req_o,
  output logic mem_we_o,
  output logic [ADDR_W-1:0] mem_addr_o,
  output logic [DATA_W-1:0] mem_wdata_o,
  input  logic [DATA_W-1:0] mem_rdata_i,
  input  logic mem_ack_i
);

  logic miss_v, st_op_v, tagfl_op_v, afl_op_v, aflinv_op_v, ainv_op_v;
  logic [ADDR_W-1:0] addr_v, dma_addr;
  logic [1:0][TAG_W-1:0] tag_v;
  logic [1:0] valid_v, tag_hit_v, dirty;
  logic mru, ack, recover, done, chosen_set;
  logic stat_mem_v, stat_mem_w, tag_mem_v, tag_mem_w;
  logic [IDX_W-1:0] stat_mem_addr, tag_mem_addr;
  logic [2:0] stat_mem_data, stat_mem_w_mask;
  logic [1:0][TAG_W:0] tag_mem_data, tag_mem_w_mask;
  logic send_fill_addr, send_evict_addr, get_fill_data, send_evict_data, dma_set, dma_done;
  logic dma_data_v, dma_data_w;
  logic [DADDR_W-1:0] dma_data_addr;
  logic [DATA_W-1:0] dma_data_wdata, dma_data_rdata;

  cache_core core (
    .clk_i, .reset_i, .req_v_i, .req_op_i, .req_addr_i, .req_data_i,
    .ready_o, .resp_v_o, .resp_data_o,
    .miss_v_o(miss_v), .st_op_v_o(st_op_v), .tagfl_op_v_o(tagfl_op_v),
    .afl_op_v_o(afl_op_v), .aflinv_op_v_o(aflinv_op_v), .ainv_op_v_o(ainv_op_v),
    .addr_v_o(addr_v), .tag_v_o(tag_v), .valid_v_o(valid_v), .tag_hit_v_o(tag_hit_v),
    .dirty_o(dirty), .mru_o(mru), .ack_o(ack),
    .stat_mem_v_i(stat_mem_v), .stat_mem_w_i(stat_mem_w), .stat_mem_addr_i(stat_mem_addr),
    .stat_mem_data_i(stat_mem_data), .stat_mem_w_mask_i(stat_mem_w_mask),
    .tag_mem_v_i(tag_mem_v), .tag_mem_w_i(tag_mem_w), .tag_mem_addr_i(tag_mem_addr),
    .tag_mem_data_i(tag_mem_data), .tag_mem_w_mask_i(tag_mem_w_mask),
    .recover_i(recover), .done_i(done), .chosen_set_i(chosen_set),
    .dma_data_v_i(dma_data_v), .dma_data_w_i(dma_data_w), .dma_data_addr_i(dma_data_addr),
    .dma_data_wdata_i(dma_data_wdata), .data_rdata_o(dma_data_rdata)
  );

  cache_miss miss (
    .clk_i, .reset_i,
    .miss_v_i(miss_v), .st_op_v_i(st_op_v), .tagfl_op_v_i(tagfl_op_v),
    .afl_op_v_i(afl_op_v), .aflinv_op_v_i(aflinv_op_v), .ainv_op_v_i(ainv_op_v),
    .addr_v_i(addr_v), .tag_v_i(tag_v), .valid_v_i(valid_v), .tag_hit_v_i(tag_hit_v),
    .dirty_i(dirty), .mru_i(mru), .dma_done_i(dma_done), .ack_i(ack),
    .dma_send_fill_addr_o(send_fill_addr), .dma_send_evict_addr_o(send_evict_addr),
    .dma_get_fill_data_o(get_fill_data), .dma_send_evict_data_o(send_evict_data),
    .dma_set_o(dma_set), .dma_addr_o(dma_addr),
    .stat_mem_v_o(stat_mem_v), .stat_mem_w_o(stat_mem_w), .stat_mem_addr_o(stat_mem_addr),
    .stat_mem_data_o(stat_mem_data), .stat_mem_w_mask_o(stat_mem_w_mask),
    .tag_mem_v_o(tag_mem_v), .tag_mem_w_o(tag_mem_w), .tag_mem_addr_o(tag_mem_addr),
    .tag_mem_data_o(tag_mem_data), .tag_mem_w_mask_o(tag_mem_w_mask),
    .recover_o(recover), .done_o(done), .chosen_set_o(chosen_set)
  );

  cache_dma dma (
    .clk_i, .reset_i,
    .send_fill_addr_i(send_fill_addr), .send_evict_addr_i(send_evict_addr),
    .get_fill_data_i(get_fill_data), .send_evict_data_i(send_evict_data),
    .set_i(dma_set), .addr_i(dma_addr), .data_rdata_i(dma_data_rdata),
    .mem_rdata_i, .mem_ack_i, .done_o(dma_done),
    .data_v_o(dma_data_v), .data_w_o(dma_data_w), .data_addr_o(dma_data_addr),
    .data_wdata_o(dma_data_wdata),
    .mem_req_o, .mem_we_o, .mem_addr_o, .mem_wdata_o
  );

endmodule

/* tb/cache_tb_clock.sv */
/*
  Clock and reset source for the cache testbench.
*/
module cache_tb_clock (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (5) @(posedge clk_o);
    #10 reset_o = 1'b0; // Released with the other inputs, after the edge.
  end

endmodule

/* tb/cache_assertions.sv */
/*
  Protocol assertions for the cache top level.
  Covers DMA commands, the memory handshake, recovery and reset values.
*/
`include "cache_macros.svh"

module cache_assertions (
  input logic clk_i,
  input logic reset_i,
  input logic ready_i,
  input logic resp_v_i,
  input logic send_fill_addr_i,
  input logic send_evict_addr_i,
  input logic send_evict_data_i,
  input logic get_fill_data_i,
  input logic mem_req_i,
  input logic mem_we_i,
  input logic [`CACHE_ADDR_WIDTH-1:0] mem_addr_i,
  input logic mem_ack_i,
  input cache_pkg::miss_state_e miss_state_i,
  input dma_pkg::dma_state_e dma_state_i
);

  one_dma_command: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0({send_fill_addr_i, send_evict_addr_i, send_evict_data_i, get_fill_data_i}))
    else $error("More than one DMA command is active.");

  // A memory request may not move until it is acknowledged.
  mem_request_held: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_i && !mem_ack_i |=> mem_req_i && $stable(mem_addr_i) && $stable(mem_we_i))
    else $error("Memory request changed before its acknowledge.");

  recover_then_done: assert property (@(posedge clk_i) disable iff (reset_i)
    miss_state_i == cache_pkg::RECOVER |=> miss_state_i == cache_pkg::DONE)
    else $error("Miss controller left RECOVER for a state other than DONE.");

  reset_values: assert property (@(posedge clk_i)
    reset_i |=> ready_i && !resp_v_i && miss_state_i == cache_pkg::START
      && dma_state_i == dma_pkg::DMA_IDLE)
    else $error("Wrong handshake or state values after reset.");

endmodule

bind cache_top cache_assertions protocol_checks (
  .clk_i, .reset_i,
  .ready_i(ready_o), .resp_v_i(resp_v_o),
  .send_fill_addr_i(send_fill_addr), .send_evict_addr_i(send_evict_addr),
  .send_evict_data_i(send_evict_data), .get_fill_data_i(get_fill_data),
  .mem_req_i(mem_req_o), .mem_we_i(mem_we_o), .mem_addr_i(mem_addr_o), .mem_ack_i,
  .miss_state_i(miss.state_r), .dma_state_i(dma.state_r)
);

/* tb/cache_tb.sv */
/*
  Testbench for the two-way cache: backing memory model, reference model,
  directed and random stimulus, response compare, watchdog and summary.
*/
`include "cache_macros.svh"

module cache_tb;

  localparam int ADDR_W = `CACHE_ADDR_WIDTH;
  localparam int DATA_W = `CACHE_DATA_WIDTH;
  localparam int WIDX_W = ADDR_W - 2;
  localparam int MEM_WORDS = 1 << WIDX_W;
  localparam int RANDOM_OPS = 300;
  localparam int DIRECTED_OPS = 40;
  // A random step issues at most two operations, and the final flush two per set.
  localparam int TIMEOUT_CYCLES = (DIRECTED_OPS + 2 * RANDOM_OPS + 2 * `CACHE_SETS) * 200;

  logic clk, reset;
  logic req_v, ready, resp_v, mem_req, mem_we, mem_ack;
  cache_pkg::cache_op_e req_op;
  logic [ADDR_W-1:0] req_addr, mem_addr;
  logic [DATA_W-1:0] req_data, resp_data, mem_wdata, mem_rdata;

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic [DATA_W-1:0] shadow [logic [WIDX_W-1:0]]; // Last stored word in program order.
  logic [DATA_W-1:0] exp_q [$];
  bit hit_q [$];
  int unsigned acc_q [$];
  int unsigned cycle = 0;
  int unsigned checks = 0;
  int unsigned errors = 0;
  int unsigned mem_writes = 0;
  int unsigned mem_reads = 0;

  cache_tb_clock clock_gen (.clk_o(clk), .reset_o(reset));

  cache_top UUT (
    .clk_i(clk), .reset_i(reset),
    .req_v_i(req_v), .req_op_i(req_op), .req_addr_i(req_addr), .req_data_i(req_data),
    .ready_o(ready), .resp_v_o(resp_v), .resp_data_o(resp_data),
    .mem_req_o(mem_req), .mem_we_o(mem_we), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
    .mem_rdata_i(mem_rdata), .mem_ack_i(mem_ack)
  );

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [DATA_W-1:0] init_word(logic [WIDX_W-1:0] widx);
    return {4'hc, widx, ~widx};
  endfunction

  function automatic logic [DATA_W-1:0] expected_word(logic [WIDX_W-1:0] widx);
    if (shadow.exists(widx)) begin
      return shadow[widx];
    end
    return init_word(widx);
  endfunction

  function automatic logic [ADDR_W-1:0] make_addr(int tag, int idx, int off);
    return {9'(tag), 3'(idx), 2'(off), 2'b00};
  endfunction

  task automatic check(input string name, input logic [DATA_W-1:0] got,
                       input logic [DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Sends one request and records what its response must be.
  task automatic issue(input cache_pkg::cache_op_e op, input logic [ADDR_W-1:0] addr,
                       input logic [DATA_W-1:0] data, input bit hit);
    req_v = 1'b1;
    req_op = op;
    req_addr = addr;
    req_data = data;
    if (op == cache_pkg::OP_ST) begin
      shadow[addr[ADDR_W-1:2]] = data;
    end
    exp_q.push_back((op == cache_pkg::OP_LD) ? expected_word(addr[ADDR_W-1:2]) : '0);
    @(negedge clk);
    while (!ready) @(negedge clk);
    @(posedge clk);
    #10;
    acc_q.push_back(cycle);
    hit_q.push_back(hit);
    req_v = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(negedge clk);
    @(posedge clk);
    #10;
  endtask

  task automatic check_word(input logic [WIDX_W-1:0] widx);
    check($sformatf("mem[%h]", widx), mem[widx], expected_word(widx));
  endtask

  task automatic check_block(input logic [ADDR_W-1:0] addr);
    for (int i = 0; i < `CACHE_BLOCK_WORDS; i++) begin
      check_word({addr[ADDR_W-1:4], 2'(i)});
    end
  endtask

  task automatic discard_block(input logic [ADDR_W-1:0] addr);
    for (int i = 0; i < `CACHE_BLOCK_WORDS; i++) begin
      shadow.delete({addr[ADDR_W-1:4], 2'(i)});
    end
  endtask

  task automatic end_test(input string name, input int unsigned errs_before);
    if (errors == errs_before) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  // Answers each request after 0 to 3 extra cycles.
  initial begin : memory_model
    int unsigned delay;
    logic [WIDX_W-1:0] widx;
    mem_ack = 1'b0;
    mem_rdata = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = init_word(WIDX_W'(i));
    end
    forever begin
      @(posedge clk);
      #10;
      mem_ack = 1'b0;
      if (mem_req) begin
        delay = $urandom_range(3);
        repeat (delay) begin
          @(posedge clk);
          #10;
        end
        widx = mem_addr[ADDR_W-1:2];
        if (mem_we) begin
          mem[widx] = mem_wdata;
          mem_writes++;
        end else begin
          mem_rdata = mem[widx];
          mem_reads++;
        end
        mem_ack = 1'b1;
      end
    end
  end

  initial begin : compare
    logic [DATA_W-1:0] exp_data;
    bit hit;
    int unsigned acc;
    forever begin
      @(negedge clk);
      if (resp_v && exp_q.size() == 0) begin
        errors++;
        $display("Unexpected response at t=%0t with no request outstanding", $time);
      end else if (resp_v) begin
        exp_data = exp_q.pop_front();
        hit = hit_q.pop_front();
        acc = acc_q.pop_front();
        check("resp_data_o", resp_data, exp_data);
        if (hit) begin
          check("resp_v_o delay", cycle - acc, '0); // A hit answers in the next cycle.
        end
      end
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin : stimulus
    int unsigned errs;
    int unsigned base;
    cache_pkg::cache_op_e op;
    logic [ADDR_W-1:0] addr;
    void'($urandom(66988));
    req_v = 1'b0;
    req_op = cache_pkg::OP_LD;
    req_addr = '0;
    req_data = '0;
    @(negedge reset);
    @(posedge clk);
    #10;

    errs = errors;
    issue(cache_pkg::OP_LD, make_addr(1, 0, 0), '0, 1'b0);
    for (int i = 0; i < 4; i++) begin
      issue(cache_pkg::OP_LD, make_addr(1, 0, i), '0, 1'b1);
    end
    issue(cache_pkg::OP_ST, make_addr(1, 0, 2), $urandom, 1'b1);
    issue(cache_pkg::OP_LD, make_addr(1, 0, 2), '0, 1'b1);
    drain();
    end_test("1 load hits", errs);

    errs = errors;
    issue(cache_pkg::OP_LD, make_addr(2, 1, 1), '0, 1'b0);
    issue(cache_pkg::OP_LD, make_addr(2, 1, 2), '0, 1'b1);
    drain();
    end_test("2 cold misses", errs);

    // Three tags on set 2; the third store pushes the first block out.
    errs = errors;
    for (int i = 0; i < 4; i++) begin
      issue(cache_pkg::OP_ST, make_addr(3, 2, i), $urandom, 1'b0);
    end
    issue(cache_pkg::OP_ST, make_addr(4, 2, 1), $urandom, 1'b0);
    issue(cache_pkg::OP_ST, make_addr(5, 2, 2), $urandom, 1'b0);
    drain();
    check_block(make_addr(3, 2, 0));
    for (int i = 0; i < 4; i++) begin
      issue(cache_pkg::OP_LD, make_addr(3, 2, i), '0, 1'b0);
    end
    drain();
    end_test("3 dirty eviction", errs);

    errs = errors;
    issue(cache_pkg::OP_ST, make_addr(6, 3, 1), $urandom, 1'b0);
    issue(cache_pkg::OP_AFL, make_addr(6, 3, 0), '0, 1'b0);
    drain();
    check_block(make_addr(6, 3, 0));
    issue(cache_pkg::OP_ST, make_addr(6, 3, 2), $urandom, 1'b1);
    issue(cache_pkg::OP_AFLINV, make_addr(6, 3, 0), '0, 1'b0);
    drain();
    check_block(make_addr(6, 3, 0));
    base = mem_reads;
    issue(cache_pkg::OP_LD, make_addr(6, 3, 2), '0, 1'b0);
    drain();
    check("memory reads", mem_reads - base, `CACHE_BLOCK_WORDS); // The line is filled again.
    end_test("4 address flush and flush-invalidate", errs);

    errs = errors;
    base = mem_writes;
    issue(cache_pkg::OP_ST, make_addr(7, 4, 0), $urandom, 1'b0);
    issue(cache_pkg::OP_AINV, make_addr(7, 4, 0), '0, 1'b0);
    drain();
    check("memory writes", mem_writes - base, '0);
    discard_block(make_addr(7, 4, 0)); // The dirty data never reached memory.
    issue(cache_pkg::OP_LD, make_addr(7, 4, 0), '0, 1'b0);
    drain();
    end_test("5 address invalidate", errs);

    errs = errors;
    for (int i = 0; i < RANDOM_OPS; i++) begin
      op = cache_pkg::cache_op_e'($urandom_range(5));
      addr = make_addr($urandom_range(3), $urandom_range(7), $urandom_range(3));
      if (op == cache_pkg::OP_AINV) begin
        issue(cache_pkg::OP_AFL, addr, '0, 1'b0); // Cleans the line so nothing is lost.
      end
      issue(op, addr, $urandom, 1'b0);
    end
    for (int s = 0; s < `CACHE_SETS; s++) begin
      issue(cache_pkg::OP_TAGFL, {8'd0, 1'b0, 3'(s), 4'd0}, '0, 1'b0);
      issue(cache_pkg::OP_TAGFL, {8'd0, 1'b1, 3'(s), 4'd0}, '0, 1'b0);
    end
    drain();
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_word(WIDX_W'(i));
    end
    end_test("6 random mix and tag flush", errs);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+include
logic/cache_pkg.sv
logic/dma_pkg.sv
logic/cache_miss.sv
logic/cache_dma.sv
logic/cache_core.sv
logic/cache_top.sv
tb/cache_tb_clock.sv
tb/cache_assertions.sv
tb/cache_tb.sv

/* run.sh */
#!/bin/sh
# Builds the cache testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module cache_tb -f build.f -o cache_sim

status=0
./obj_dir/cache_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "=== FAIL ===" sim.log; then
  echo "Simulation reported errors, see sim.log"
  exit 1
fi
echo "Simulation finished without errors"
